/* common/popeye_video_params.svh */
// address widths and download map of the colour PROMs; regions must stay aligned to their size
`ifndef POPEYE_VIDEO_PARAMS_SVH
`define POPEYE_VIDEO_PARAMS_SVH

// palette address widths
`define BAK_AW 5          // background and text palettes, 32 words
`define OBJ_AW 8          // object palettes, 256 words

// download bus
`define DL_AW 10          // linear download address width

// download region bases
// each region is aligned to its own size
`define DL_BAK_BASE    10'h000   // 32 bytes, background palette
`define DL_TXT_BASE    10'h020   // 32 bytes, text palette
`define DL_OBJ_LO_BASE 10'h100   // 256 bytes, low nibble of object colour
`define DL_OBJ_HI_BASE 10'h200   // 256 bytes, data low nibble goes to word high nibble

// 10'h040 to 10'h0ff and 10'h300 up are unmapped

`endif

/* common/popeye_video_pkg.sv */
// colour stage types only; the palette word layout is fixed by the board PROMs (3-3-2, MSB first)
package popeye_video_pkg;

    // one palette PROM word split into its colour fields
    // r in the top three bits, blue gets only two bits
    typedef struct packed {
        logic [2:0] r;  // red, bits 7:5
        logic [2:0] g;  // green, bits 4:2
        logic [1:0] b;  // blue high bits, low bit is always zero at the output
    } palette_rgb_t;

    // same byte seen two ways
    // raw as written by the download bus, rgb as read by the mixer
    typedef union packed {
        logic [7:0]   raw;
        palette_rgb_t rgb;
    } palette_word_t;

    // layer latched for the current pixel
    // priority is text, then object, then background
    typedef enum logic [1:0] {
        LAYER_NONE = 2'd0,  // blanked or nothing visible, drives black
        LAYER_TXT  = 2'd1,  // text plane, txtv low
        LAYER_OBJ  = 2'd2,  // sprite pixel, objv nonzero
        LAYER_BAK  = 2'd3   // background, only outside blanking
    } layer_sel_t;

    // object palette is split over two 4-bit PROMs
    // lo PROM gives bits 3:0, hi PROM bits 7:4
    // both are stored in 8-bit words, the unused nibble is ignored

    // text palette is addressed by {txtc[3], txtc}
    // so only 16 of its 32 words can ever be shown

    // background palette addressed directly by bakc

endpackage

/* common/prom_prog_if.sv */
// PROM programming bus; at most one write strobe high per cycle, addr and din valid with it
`timescale 1ns/10ps

interface prom_prog_if;

    logic [7:0] addr;       // word address inside the selected PROM
    logic [7:0] din;        // write data, already nibble-aligned for the object PROMs
    logic       we_bak;     // background palette
    logic       we_txt;     // text palette
    logic       we_obj_lo;  // object palette, bits 3:0
    logic       we_obj_hi;  // object palette, bits 7:4

    // loader side drives everything
    modport loader (
        output addr,
        output din,
        output we_bak,
        output we_txt,
        output we_obj_lo,
        output we_obj_hi
    );

    // mixer side only consumes
    modport mixer (
        input addr,
        input din,
        input we_bak,
        input we_txt,
        input we_obj_lo,
        input we_obj_hi
    );

endinterface

/* colmix/palette_prom.sv */
// RAM-backed colour PROM, up to 256 x 8; contents are undefined until downloaded and survive reset
`timescale 1ns/10ps

module palette_prom (
    input  logic       clk,
    input  logic       cen,      // pixel enable, gates the read only
    input  logic [7:0] rd_addr,  // tie upper bits low for small palettes
    input  logic [7:0] wr_addr,
    input  logic       we,       // download strobe, works on any clk
    input  logic [7:0] data,
    output logic [7:0] q
);

    // full 256 deep array
    // words above a tied-low address range are never touched and get trimmed
    logic [7:0] mem [0:255];

    // download write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    // read port, registered like the original bipolar PROM
    // followed by its output latch
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];  // visible after the same enabled edge
        end
    end

    // a write and a read to the same word on one edge
    // returns the old word, which only matters during download

endmodule

/* colmix/colmix.sv */
// colour mixer; layer priority is fixed (text, object, background), RGB lags the pixel by two pxl_cen
`timescale 1ns/10ps

`include "popeye_video_params.svh"

module colmix (
    input  logic                clk,
    input  logic                reset,
    input  logic                pxl_cen,   // pixel clock enable
    prom_prog_if.mixer          prog,      // palette download writes
    input  logic [`BAK_AW-1:0]  bakc,      // background colour code
    input  logic [5:0]          objc,      // object colour code
    input  logic [1:0]          objv,      // object pixel, zero is transparent
    input  logic [3:0]          txtc,      // text colour code
    input  logic                txtv,      // text visible, active low
    input  logic                hbd_n,     // horizontal background blank
    input  logic                vb_n,      // vertical blank
    output logic [2:0]          red,
    output logic [2:0]          green,
    output logic [2:0]          blue       // bit 0 always zero
);
    import popeye_video_pkg::*;

    logic [7:0]        bak_rd_addr;
    logic [7:0]        txt_rd_addr;
    logic [`OBJ_AW-1:0] obj_rd_addr;
    logic [7:0]        bak_wr_addr;     // 32-word PROMs use only the low address bits
    logic [7:0]        bak_q;
    logic [7:0]        txt_q;
    logic [7:0]        obj_lo_q;
    logic [7:0]        obj_hi_q;

    palette_word_t     bak_word;
    palette_word_t     txt_word;
    palette_word_t     obj_word;
    palette_word_t     sel_word;       // word of the latched layer

    layer_sel_t        layer;          // latched together with the PROM reads

    // read addresses
    assign bak_rd_addr = {{(8-`BAK_AW){1'b0}}, bakc};
    assign txt_rd_addr = {3'b000, txtc[3], txtc};  // bit 3 doubled, half the PROM unreachable
    assign obj_rd_addr = {objc, objv};
    assign bak_wr_addr = {{(8-`BAK_AW){1'b0}}, prog.addr[`BAK_AW-1:0]};

    // background palette
    palette_prom i_prom_bak (
        .clk     (clk),
        .cen     (pxl_cen),
        .rd_addr (bak_rd_addr),
        .wr_addr (bak_wr_addr),
        .we      (prog.we_bak),
        .data    (prog.din),
        .q       (bak_q)
    );

    // text palette, same 32-word map as the background
    palette_prom i_prom_txt (
        .clk     (clk),
        .cen     (pxl_cen),
        .rd_addr (txt_rd_addr),
        .wr_addr (bak_wr_addr),
        .we      (prog.we_txt),
        .data    (prog.din),
        .q       (txt_q)
    );

    // object palette, low nibble
    palette_prom i_prom_obj_lo (
        .clk     (clk),
        .cen     (pxl_cen),
        .rd_addr (obj_rd_addr),
        .wr_addr (prog.addr),
        .we      (prog.we_obj_lo),
        .data    (prog.din),       // loader leaves the nibble in bits 3:0
        .q       (obj_lo_q)
    );

    // object palette, high nibble
    palette_prom i_prom_obj_hi (
        .clk     (clk),
        .cen     (pxl_cen),
        .rd_addr (obj_rd_addr),
        .wr_addr (prog.addr),
        .we      (prog.we_obj_hi),
        .data    (prog.din),       // loader already shifted it to bits 7:4
        .q       (obj_hi_q)
    );

    assign bak_word.raw = bak_q;
    assign txt_word.raw = txt_q;
    assign obj_word.raw = {obj_hi_q[7:4], obj_lo_q[3:0]};  // other nibbles are don't care

    // priority latch, sampled with the same edge as the PROM reads
    always_ff @(posedge clk) begin
        if (reset) begin
            layer <= LAYER_NONE;
        end else if (pxl_cen) begin
            if (!txtv) begin
                layer <= LAYER_TXT;     // text wins even over blanking
            end else if (|objv) begin
                layer <= LAYER_OBJ;     // sprites ignore hbd_n and vb_n
            end else if (hbd_n && vb_n) begin
                layer <= LAYER_BAK;
            end else begin
                layer <= LAYER_NONE;    // blanked
            end
        end
    end

    // colour merge
    always_comb begin
        case (layer)
            LAYER_TXT: sel_word = txt_word;
            LAYER_OBJ: sel_word = obj_word;
            LAYER_BAK: sel_word = bak_word;
            default:   sel_word.raw = 8'h00;  // black
        endcase
    end

    // RGB register, one enabled edge after the latch
    always_ff @(posedge clk) begin
        if (reset) begin
            red   <= 3'd0;
            green <= 3'd0;
            blue  <= 3'd0;
        end else if (pxl_cen) begin
            red   <= sel_word.rgb.r;
            green <= sel_word.rgb.g;
            blue  <= {sel_word.rgb.b, 1'b0};  // no third blue bit on the board
        end
    end

endmodule

/* logic/prom_loader.sv */
// download decoder; writes land one clk after dl_we, addresses outside the four regions are dropped
`timescale 1ns/10ps

`include "popeye_video_params.svh"

module prom_loader (
    input  logic              clk,
    input  logic              reset,
    input  logic [`DL_AW-1:0] dl_addr,  // linear download address
    input  logic [7:0]        dl_data,
    input  logic              dl_we,    // one write per high cycle
    prom_prog_if.loader       prog
);

    logic in_bak;
    logic in_txt;
    logic in_obj_lo;
    logic in_obj_hi;

    // region match on the bits above each region's size
    // regions are aligned, so a shift compare is enough
    assign in_bak    = (dl_addr >> `BAK_AW) == (`DL_BAK_BASE >> `BAK_AW);
    assign in_txt    = (dl_addr >> `BAK_AW) == (`DL_TXT_BASE >> `BAK_AW);
    assign in_obj_lo = (dl_addr >> `OBJ_AW) == (`DL_OBJ_LO_BASE >> `OBJ_AW);
    assign in_obj_hi = (dl_addr >> `OBJ_AW) == (`DL_OBJ_HI_BASE >> `OBJ_AW);

    // strobes, at most one of them per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            prog.we_bak    <= 1'b0;
            prog.we_txt    <= 1'b0;
            prog.we_obj_lo <= 1'b0;
            prog.we_obj_hi <= 1'b0;
        end else begin
            prog.we_bak    <= dl_we && in_bak;
            prog.we_txt    <= dl_we && in_txt;
            prog.we_obj_lo <= dl_we && in_obj_lo;
            prog.we_obj_hi <= dl_we && in_obj_hi;
        end
    end

    // address and data follow the strobe
    // held between writes
    always_ff @(posedge clk) begin
        if (dl_we) begin
            prog.addr <= dl_addr[7:0];     // small PROMs use the low 5 bits only
            if (in_obj_hi) begin
                prog.din <= {dl_data[3:0], 4'h0};  // high nibble PROM
            end else begin
                prog.din <= dl_data;
            end
        end
    end

    // obj lo keeps the nibble in bits 3:0 as downloaded
    // the mixer picks the nibble it needs from each PROM

endmodule

/* logic/video_out.sv */
// colour stage top; pixel to RGB is two pxl_cen edges, download to visible adds two clk cycles
`timescale 1ns/10ps

`include "popeye_video_params.svh"

module video_out (
    input  logic              clk,
    input  logic              reset,
    // palette download
    input  logic [`DL_AW-1:0] dl_addr,
    input  logic [7:0]        dl_data,
    input  logic              dl_we,
    // pixel side
    input  logic              pxl_cen,
    input  logic [`BAK_AW-1:0] bakc,
    input  logic [5:0]        objc,
    input  logic [1:0]        objv,
    input  logic [3:0]        txtc,
    input  logic              txtv,    // active low
    input  logic              hbd_n,
    input  logic              vb_n,
    // video out, 3-3-3
    output logic [2:0]        red,
    output logic [2:0]        green,
    output logic [2:0]        blue
);

    prom_prog_if prog_bus ();  // loader to mixer

    // download address decode and write strobes
    prom_loader i_loader (
        .clk     (clk),
        .reset   (reset),
        .dl_addr (dl_addr),
        .dl_data (dl_data),
        .dl_we   (dl_we),
        .prog    (prog_bus.loader)
    );

    // priority, palettes and RGB register
    colmix i_colmix (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .prog    (prog_bus.mixer),
        .bakc    (bakc),
        .objc    (objc),
        .objv    (objv),
        .txtc    (txtc),
        .txtv    (txtv),
        .hbd_n   (hbd_n),
        .vb_n    (vb_n),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

endmodule

/* tests/video_out_tb.sv */
// directed tests for the colour stage; palettes are loaded over the download bus, pxl_cen every other clk
`timescale 1ns/10ps

`include "popeye_video_params.svh"

module video_out_tb;
    import popeye_video_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int N_DOWNLOADS = 32 + 32 + 256 + 256 + 2;  // full load plus decode test
    localparam int N_PIXELS    = 40 * 3 + 240 + 64 + 5 * 2;  // tests plus pipeline flush
    localparam int TIMEOUT_NS  = (N_DOWNLOADS + N_PIXELS + 16) * 16 * CLK_PERIOD;

    // one pixel worth of layer inputs
    typedef struct packed {
        logic [`BAK_AW-1:0] bakc;
        logic [5:0]         objc;
        logic [1:0]         objv;
        logic [3:0]         txtc;
        logic               txtv;
        logic               hbd_n;
        logic               vb_n;
    } pixel_t;

    logic              clk;
    logic              reset;
    logic [`DL_AW-1:0] dl_addr;
    logic [7:0]        dl_data;
    logic              dl_we;
    logic              pxl_cen;
    logic [`BAK_AW-1:0] bakc;
    logic [5:0]        objc;
    logic [1:0]        objv;
    logic [3:0]        txtc;
    logic              txtv;
    logic              hbd_n;
    logic              vb_n;
    logic [2:0]        red;
    logic [2:0]        green;
    logic [2:0]        blue;

    // reference palettes, bytes as downloaded
    logic [7:0] bak_pal    [0:31];
    logic [7:0] txt_pal    [0:31];
    logic [7:0] obj_lo_pal [0:255];  // low nibble used
    logic [7:0] obj_hi_pal [0:255];  // low nibble becomes word bits 7:4

    pixel_t      pix_q [$];  // pixels for the next playback

    video_out i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // pixel enable on every second edge
    always @(posedge clk) begin
        #1;
        pxl_cen = ~pxl_cen;
    end

    // layer priority first, then the palette lookup
    function automatic logic [8:0] expected_rgb(input pixel_t p);
        palette_word_t w;
        logic [7:0]    oi;
        oi = {p.objc, p.objv};
        if (!p.txtv) begin
            w.raw = txt_pal[{p.txtc[3], p.txtc}];  // txtc bit 3 doubled
        end else if (p.objv != 2'd0) begin
            w.raw = {obj_hi_pal[oi][3:0], obj_lo_pal[oi][3:0]};
        end else if (p.hbd_n && p.vb_n) begin
            w.raw = bak_pal[p.bakc];
        end else begin
            w.raw = 8'h00;  // blanked
        end
        return {w.rgb.r, w.rgb.g, w.rgb.b, 1'b0};
    endfunction

    function automatic pixel_t random_pixel();
        pixel_t p;
        p = $urandom();  // truncated to the struct width
        return p;
    endfunction

    task automatic check_rgb(input logic [8:0] exp);
        assert (red === exp[8:6]) else begin
            $display("Error red: expected %h, actual %h", exp[8:6], red);
            $display("tests failed");
            $fatal(1, "red mismatch");
        end
        assert (green === exp[5:3]) else begin
            $display("Error green: expected %h, actual %h", exp[5:3], green);
            $display("tests failed");
            $fatal(1, "green mismatch");
        end
        assert (blue === exp[2:0]) else begin
            $display("Error blue: expected %h, actual %h", exp[2:0], blue);
            $display("tests failed");
            $fatal(1, "blue mismatch");
        end
    endtask

    // returns 1 ns after the next edge that has pxl_cen high
    task automatic next_pixel_edge();
        @(posedge clk);
        while (pxl_cen !== 1'b1) @(posedge clk);
        #1;
    endtask

    task automatic apply_pixel(input pixel_t p);
        bakc  = p.bakc;
        objc  = p.objc;
        objv  = p.objv;
        txtc  = p.txtc;
        txtv  = p.txtv;
        hbd_n = p.hbd_n;
        vb_n  = p.vb_n;
    endtask

    // one download write starting 1 ns after an edge
    task automatic write_byte(input logic [`DL_AW-1:0] addr, input logic [7:0] data);
        dl_addr = addr;
        dl_data = data;
        dl_we   = 1'b1;
        @(posedge clk);
        #1;
        dl_we   = 1'b0;
    endtask

    // drives the queued pixels back to back, each checked two enabled edges later
    task automatic play_pixels();
        int           i;
        int           n;
        logic [8:0]   exp_q [$];
        pixel_t       idle;
        n    = pix_q.size();
        idle = '{bakc: 0, objc: 0, objv: 0, txtc: 0, txtv: 1'b1, hbd_n: 1'b0, vb_n: 1'b0};
        for (i = 0; i < n + 2; i++) begin
            next_pixel_edge();
            if (i >= 2) check_rgb(exp_q.pop_front());  // pixel from edge i-2
            if (i < n) begin
                exp_q.push_back(expected_rgb(pix_q[i]));
                apply_pixel(pix_q[i]);
            end else begin
                apply_pixel(idle);  // black while flushing
            end
        end
        pix_q.delete();
    endtask

    task automatic load_palettes();
        int i;
        for (i = 0; i < 32; i++) begin
            bak_pal[i] = $urandom();
            txt_pal[i] = $urandom();
            write_byte(`DL_BAK_BASE + i, bak_pal[i]);
            write_byte(`DL_TXT_BASE + i, txt_pal[i]);
        end
        for (i = 0; i < 256; i++) begin
            obj_lo_pal[i] = $urandom();
            obj_hi_pal[i] = $urandom();
            write_byte(`DL_OBJ_LO_BASE + i, obj_lo_pal[i]);
            write_byte(`DL_OBJ_HI_BASE + i, obj_hi_pal[i]);
        end
        repeat (2) @(posedge clk);  // last write lands
        #1;
    endtask

    task automatic reset_gives_black();
        check_rgb(9'h000);  // no enabled edge since reset went low
    endtask

    task automatic text_priority();
        pixel_t p;
        repeat (40) begin
            p      = random_pixel();
            p.txtv = 1'b0;  // beats objects and blanking
            pix_q.push_back(p);
        end
        play_pixels();
    endtask

    task automatic object_layer();
        pixel_t p;
        repeat (40) begin
            p      = random_pixel();
            p.txtv = 1'b1;
            p.objv = 2'd1 + ($urandom() % 3);  // nonzero
            pix_q.push_back(p);
        end
        play_pixels();
    endtask

    task automatic background_layer();
        int     i;
        pixel_t p;
        for (i = 0; i < 40; i++) begin
            p      = random_pixel();
            p.txtv = 1'b1;
            p.objv = 2'd0;
            if (i < 4) begin
                p.hbd_n = i[0];  // every blank combination at least once
                p.vb_n  = i[1];
            end
            pix_q.push_back(p);
        end
        play_pixels();
    endtask

    task automatic loader_decode();
        int         i;
        int         idx;
        logic [7:0] junk;
        pixel_t     p;
        idx          = $urandom() % 32;
        bak_pal[idx] = ~bak_pal[idx];  // every field changes
        write_byte(`DL_BAK_BASE + idx, bak_pal[idx]);
        junk = $urandom();
        write_byte(10'h080, junk);  // unmapped so the model stays untouched
        repeat (2) @(posedge clk);
        #1;
        p = '{bakc: 0, objc: 0, objv: 0, txtc: 0, txtv: 1'b1, hbd_n: 1'b1, vb_n: 1'b1};
        for (i = 0; i < 32; i++) begin
            p.bakc = i;
            pix_q.push_back(p);
        end
        p.txtv = 1'b0;
        for (i = 0; i < 16; i++) begin
            p.txtc = i;
            pix_q.push_back(p);
        end
        p.txtv = 1'b1;
        for (i = 0; i < 256; i++) begin
            p.objc = i[7:2];
            p.objv = i[1:0];
            if (p.objv != 2'd0) pix_q.push_back(p);  // objv zero is transparent
        end
        play_pixels();
    endtask

    task automatic pixel_stream();
        repeat (64) pix_q.push_back(random_pixel());  // all layers mixed
        play_pixels();
    endtask

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run took longer than its time limit");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'hc7ee));
        clk      = 1'b0;
        reset    = 1'b1;
        pxl_cen  = 1'b0;
        dl_addr  = '0;
        dl_data  = 8'h00;
        dl_we    = 1'b0;
        apply_pixel('{bakc: 0, objc: 0, objv: 0, txtc: 0, txtv: 1'b1, hbd_n: 1'b0, vb_n: 1'b0});
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_gives_black();
        load_palettes();
        text_priority();
        object_layer();
        background_layer();
        loader_decode();
        pixel_stream();
        $display("all tests passed");
        $finish;
    end

endmodule

/* video_out.f */
+incdir+common
common/popeye_video_pkg.sv
common/prom_prog_if.sv
colmix/palette_prom.sv
colmix/colmix.sv
logic/prom_loader.sv
logic/video_out.sv
tests/video_out_tb.sv
